/* Bender.yml */
package:
  name: sd_emmc_controller

sources:
  - sd_pkg.sv
  - sd_apb_regs.sv
  - sd_clock_divider.sv
  - sd_cmd_master.sv
  - sd_cmd_serial_host.sv
  - sd_emmc_controller.sv
  - target: test
    files:
      - sd_card_model.sv
      - tb_sd_emmc_controller.sv

/* sd_apb_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module sd_apb_regs #(
    parameter int DIV_W = 8
) (
    input  logic                             aclk_i,
    input  logic                             reset_i,
    input  logic                             psel_i,
    input  logic                             penable_i,
    input  logic                             pwrite_i,
    input  logic [sd_pkg::APB_ADDR_W-1:0]    paddr_i,
    input  logic [31:0]                      pwdata_i,
    output logic [31:0]                      prdata_o,
    output logic                             pready_o,
    output logic                             pslverr_o,
    input  logic                             clk_stable_i,
    input  logic                             cmd_busy_i,
    input  logic [3:0][31:0]                 resp_i,
    input  sd_pkg::sd_cmd_int_t              cmd_events_i,
    output sd_pkg::sd_cmd_t                  cmd_o,
    output logic                             cmd_start_o,
    output logic [sd_pkg::CMD_TIMEOUT_W-1:0] timeout_o,
    output logic [DIV_W-1:0]                 divisor_o,
    output logic                             div_load_o,
    output logic                             soft_rst_o,
    output logic                             interrupt_o
);
    import sd_pkg::*;

    sd_cmd_t                  cmd_q;
    logic [CMD_TIMEOUT_W-1:0] timeout_q;
    logic [DIV_W-1:0]         divisor_q;
    sd_cmd_int_t              int_status_q;
    sd_cmd_int_t              int_enable_q;
    logic                     cmd_start_q;
    logic                     div_load_q;
    logic                     soft_rst_q;
    logic                     irq_q;
    logic                     access;
    logic                     wr_en;
    logic                     mapped;
    logic                     read_only;
    logic                     inhibit;
    logic [3:0]               int_clear;
    logic [31:0]              rdata;

    assign access = psel_i & penable_i;
    assign wr_en  = access & pwrite_i;

    // a launched command counts as in flight until the master picks it up
    assign inhibit = cmd_busy_i | cmd_start_q;

    assign int_clear = (wr_en && paddr_i == REG_INT_STATUS) ? pwdata_i[3:0] : 4'd0;

    always_comb begin
        rdata     = '0;
        mapped    = 1'b1;
        read_only = 1'b0;
        case (paddr_i)
            REG_ARGUMENT:   rdata = cmd_q.argument;
            REG_COMMAND:    rdata = {22'd0, cmd_q.resp, 2'd0, cmd_q.index};
            REG_TIMEOUT:    rdata = 32'(timeout_q);
            REG_CLK_DIV:    rdata = 32'(divisor_q);
            REG_RESP0, REG_RESP1, REG_RESP2, REG_RESP3: begin
                rdata     = resp_i[paddr_i[3:2]];
                read_only = 1'b1;
            end
            REG_INT_STATUS: rdata = {28'd0, int_status_q};
            REG_INT_ENABLE: rdata = {28'd0, int_enable_q};
            REG_PRESENT: begin
                rdata     = {30'd0, clk_stable_i, inhibit};
                read_only = 1'b1;
            end
            REG_SOFT_RESET: rdata = '0;
            default:        mapped = 1'b0;
        endcase
    end

    always_ff @(posedge aclk_i) begin
        if (reset_i) begin
            cmd_q        <= '0;
            timeout_q    <= '1;
            divisor_q    <= '1;
            int_status_q <= '0;
            int_enable_q <= '0;
            cmd_start_q  <= 1'b0;
            div_load_q   <= 1'b0;
            soft_rst_q   <= 1'b0;
            irq_q        <= 1'b0;
        end else begin
            cmd_start_q <= 1'b0;
            div_load_q  <= 1'b0;
            soft_rst_q  <= 1'b0;
            if (wr_en) begin
                case (paddr_i)
                    REG_ARGUMENT: cmd_q.argument <= pwdata_i;
                    REG_COMMAND: begin
                        // dropped silently while a command is in flight
                        if (!inhibit) begin
                            cmd_q.index <= pwdata_i[5:0];
                            cmd_q.resp  <= sd_resp_e'(pwdata_i[9:8]);
                            cmd_start_q <= 1'b1;
                        end
                    end
                    REG_TIMEOUT:    timeout_q <= pwdata_i[CMD_TIMEOUT_W-1:0];
                    REG_CLK_DIV: begin
                        divisor_q  <= pwdata_i[DIV_W-1:0];
                        div_load_q <= 1'b1;
                    end
                    REG_INT_ENABLE: int_enable_q <= pwdata_i[3:0];
                    REG_SOFT_RESET: soft_rst_q <= pwdata_i[0];
                    default: ;
                endcase
            end
            // a new event beats a w1c in the same cycle
            int_status_q <= (int_status_q & ~int_clear) | cmd_events_i;
            irq_q        <= |(int_status_q & int_enable_q);
        end
    end

    assign prdata_o    = rdata;
    assign pready_o    = 1'b1;
    assign pslverr_o   = access & (~mapped | (pwrite_i & read_only));
    assign cmd_o       = cmd_q;
    assign cmd_start_o = cmd_start_q;
    assign timeout_o   = timeout_q;
    assign divisor_o   = divisor_q;
    assign div_load_o  = div_load_q;
    assign soft_rst_o  = soft_rst_q;
    assign interrupt_o = irq_q;

    // every aligned offset up to the soft reset register is mapped
    mapped_read_ok: assert property (@(posedge aclk_i) disable iff (reset_i)
        (access && !pwrite_i && paddr_i[1:0] == 2'b00 && paddr_i <= REG_SOFT_RESET)
        |-> !pslverr_o);

endmodule

`default_nettype wire

/* sd_card_model.sv */
`timescale 1ns/100ps
`default_nettype none

module sd_card_model (
    input  logic aclk_i,
    input  logic sd_clk_i,
    input  logic sd_cmd_i,
    input  logic sd_cmd_oe_i,
    output logic sd_cmd_o,
    output logic frame_err_o,
    output int   frame_cnt_o
);
    logic [47:0] frame;
    logic [39:0] head;
    logic [6:0]  crc;

    // x^7 + x^3 + 1, one bit at a time
    function automatic logic [6:0] calc_crc7(input logic [39:0] bits);
        logic [6:0] r;
        logic       inv;
        r = 7'd0;
        for (int i = 39; i >= 0; i--) begin
            inv = bits[i] ^ r[6];
            r   = {r[5:3], r[2] ^ inv, r[1:0], inv};
        end
        return r;
    endfunction

    // card changes the line after the sd clock falls
    task automatic send_response(input logic [135:0] bits, input int len);
        // second sd clock after the end bit
        @(posedge sd_clk_i);
        for (int i = len - 1; i >= 0; i--) begin
            @(negedge sd_clk_i);
            @(negedge aclk_i);
            sd_cmd_o = bits[i];
        end
        @(negedge sd_clk_i);
        @(negedge aclk_i);
        sd_cmd_o = 1'b1;
    endtask

    initial begin
        sd_cmd_o    = 1'b1;
        frame_err_o = 1'b0;
        frame_cnt_o = 0;
        forever begin
            @(posedge sd_clk_i);
            if (sd_cmd_oe_i && !sd_cmd_i) begin
                frame[47] = 1'b0;
                for (int i = 46; i >= 0; i--) begin
                    @(posedge sd_clk_i);
                    frame[i] = sd_cmd_i;
                    if (!sd_cmd_oe_i) begin
                        frame_err_o = 1'b1;
                    end
                end
                if (!frame[46] || !frame[0] || frame[7:1] != calc_crc7(frame[47:8])) begin
                    frame_err_o = 1'b1;
                end
                frame_cnt_o = frame_cnt_o + 1;
                // host lets go of the line right after the end bit
                @(posedge sd_clk_i);
                if (sd_cmd_oe_i) begin
                    frame_err_o = 1'b1;
                end
                case (frame[45:40])
                    6'd2: send_response({2'b00, 6'h3f, frame[31:8], frame[39:8], ~frame[39:8],
                                         frame[39:8], 7'h7f, 1'b1}, 136);
                    // no answer at all
                    6'd5: ;
                    default: begin
                        head = {2'b00, frame[45:40], ~frame[39:8]};
                        // index 17 is answered as 18, index 13 with a broken crc
                        if (frame[45:40] == 6'd17) begin
                            head[37:32] = 6'd18;
                        end
                        crc = calc_crc7(head);
                        if (frame[45:40] == 6'd13) begin
                            crc = crc ^ 7'h01;
                        end
                        send_response({88'd0, head, crc, 1'b1}, 48);
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* sd_clock_divider.sv */
`timescale 1ns/100ps
`default_nettype none

module sd_clock_divider #(
    parameter int DIV_W = 8
) (
    input  logic             aclk_i,
    input  logic             reset_i,
    input  logic [DIV_W-1:0] divisor_i,
    input  logic             div_load_i,
    output logic             sd_clk_o,
    output logic             sd_tick_o,
    output logic             clk_stable_o
);
    logic [DIV_W-1:0] cnt_q;
    logic [1:0]       half_cnt_q;
    logic             sd_clk_q;
    logic             tick_q;
    logic             stable_q;
    logic             toggle;

    assign toggle = (cnt_q >= divisor_i);

    always_ff @(posedge aclk_i) begin
        if (reset_i || div_load_i) begin
            cnt_q      <= '0;
            half_cnt_q <= '0;
            sd_clk_q   <= 1'b0;
            tick_q     <= 1'b0;
            stable_q   <= 1'b0;
        end else begin
            // tick coincides with the first cycle of sd_clk high
            tick_q <= toggle & ~sd_clk_q;
            if (toggle) begin
                cnt_q      <= '0;
                sd_clk_q   <= ~sd_clk_q;
                half_cnt_q <= half_cnt_q + 2'd1;
                // four half periods since the load
                if (half_cnt_q == 2'd3) begin
                    stable_q <= 1'b1;
                end
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign sd_clk_o     = sd_clk_q;
    assign sd_tick_o    = tick_q;
    assign clk_stable_o = stable_q;

endmodule

`default_nettype wire

/* sd_cmd_master.sv */
`timescale 1ns/100ps
`default_nettype none

module sd_cmd_master (
    input  logic                             aclk_i,
    input  logic                             reset_i,
    input  logic                             soft_rst_i,
    input  logic                             sd_tick_i,
    input  sd_pkg::sd_cmd_t                  cmd_i,
    input  logic                             cmd_start_i,
    input  logic [sd_pkg::CMD_TIMEOUT_W-1:0] timeout_i,
    input  logic                             host_done_i,
    input  sd_pkg::sd_cmd_result_t           result_i,
    output logic                             host_start_o,
    output sd_pkg::sd_cmd_t                  host_cmd_o,
    output logic                             host_abort_o,
    output logic                             cmd_busy_o,
    output sd_pkg::sd_cmd_int_t              events_o,
    output logic [31:0]                      resp0_o,
    output logic [31:0]                      resp1_o,
    output logic [31:0]                      resp2_o,
    output logic [31:0]                      resp3_o
);
    import sd_pkg::*;

    logic                     busy_q;
    logic                     wait_q;
    logic [5:0]               tx_cnt_q;
    logic [CMD_TIMEOUT_W-1:0] to_cnt_q;
    sd_cmd_int_t              events_q;
    sd_resp_e                 resp_q;
    logic [3:0][31:0]         resp_words_q;
    logic                     timed_out;
    logic                     short_resp;
    logic [RESP_W-1:0]        payload;

    assign host_start_o = cmd_start_i & ~busy_q;
    assign host_cmd_o   = cmd_i;
    assign timed_out    = busy_q & wait_q & sd_tick_i & ~host_done_i & (to_cnt_q == timeout_i);
    assign host_abort_o = timed_out;
    assign short_resp   = (resp_q == RESP_SHORT) || (resp_q == RESP_SHORT_BUSY);

    // short frames only carry the low word
    assign payload = (resp_q == RESP_LONG) ? result_i.payload : RESP_W'(result_i.payload[31:0]);

    always_ff @(posedge aclk_i) begin
        if (reset_i || soft_rst_i) begin
            busy_q   <= 1'b0;
            wait_q   <= 1'b0;
            tx_cnt_q <= '0;
            to_cnt_q <= '0;
            events_q <= '0;
        end else begin
            events_q <= '0;
            if (host_start_o) begin
                busy_q   <= 1'b1;
                wait_q   <= 1'b0;
                tx_cnt_q <= '0;
                to_cnt_q <= '0;
            end else if (busy_q) begin
                if (host_done_i) begin
                    busy_q             <= 1'b0;
                    events_q.complete  <= 1'b1;
                    events_q.crc_err   <= short_resp & ~result_i.crc_ok;
                    events_q.index_err <= short_resp & ~result_i.index_ok;
                end else if (timed_out) begin
                    busy_q               <= 1'b0;
                    events_q.complete    <= 1'b1;
                    events_q.timeout_err <= 1'b1;
                end else if (sd_tick_i) begin
                    // timeout counts from the end bit
                    if (!wait_q) begin
                        tx_cnt_q <= tx_cnt_q + 6'd1;
                        wait_q   <= (tx_cnt_q == 6'(SHORT_FRAME_W - 1));
                    end else begin
                        to_cnt_q <= to_cnt_q + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge aclk_i) begin
        if (host_start_o) begin
            resp_q <= cmd_i.resp;
        end
        if (busy_q && host_done_i && resp_q != RESP_NONE) begin
            resp_words_q <= {8'd0, payload};
        end
    end

    assign cmd_busy_o = busy_q;
    assign events_o   = events_q;
    assign resp0_o    = resp_words_q[0];
    assign resp1_o    = resp_words_q[1];
    assign resp2_o    = resp_words_q[2];
    assign resp3_o    = resp_words_q[3];

    // the register file holds a new command back while one is in flight
    start_when_idle: assert property (@(posedge aclk_i) disable iff (reset_i || soft_rst_i)
        cmd_start_i |-> !cmd_busy_o);

endmodule

`default_nettype wire

/* sd_cmd_serial_host.sv */
`timescale 1ns/100ps
`default_nettype none

module sd_cmd_serial_host (
    input  logic                   aclk_i,
    input  logic                   reset_i,
    input  logic                   soft_rst_i,
    input  logic                   abort_i,
    input  logic                   sd_tick_i,
    input  logic                   start_i,
    input  sd_pkg::sd_cmd_t        cmd_i,
    input  logic                   sd_cmd_i,
    output logic                   sd_cmd_o,
    output logic                   sd_cmd_oe_o,
    output logic                   done_o,
    output sd_pkg::sd_cmd_result_t result_o
);
    import sd_pkg::*;

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_TX      = 3'd1;
    localparam logic [2:0] S_RX_WAIT = 3'd2;
    localparam logic [2:0] S_RX      = 3'd3;
    localparam logic [2:0] S_DONE    = 3'd4;

    logic [2:0]               state_q;
    logic [7:0]               cnt_q;
    logic                     cmd_q;
    logic                     oe_q;
    logic [SHORT_FRAME_W-1:0] tx_q;
    logic [LONG_FRAME_W-1:0]  rx_q;
    logic [5:0]               index_q;
    sd_resp_e                 resp_q;
    logic [39:0]              tx_head;
    logic [7:0]               rx_len;
    logic                     crc_ok;
    logic                     index_ok;

    // start 0, direction 1, index, argument
    assign tx_head = {2'b01, cmd_i.index, cmd_i.argument};
    assign rx_len  = (resp_q == RESP_LONG) ? 8'(LONG_FRAME_W) : 8'(SHORT_FRAME_W);

    always_ff @(posedge aclk_i) begin
        if (reset_i || soft_rst_i || abort_i) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
            cmd_q   <= 1'b1;
            oe_q    <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q <= S_TX;
                        cnt_q   <= '0;
                    end
                end
                S_TX: begin
                    if (sd_tick_i) begin
                        if (cnt_q == 8'(SHORT_FRAME_W)) begin
                            // release the line after the end bit
                            oe_q    <= 1'b0;
                            cmd_q   <= 1'b1;
                            cnt_q   <= '0;
                            state_q <= (resp_q == RESP_NONE) ? S_DONE : S_RX_WAIT;
                        end else begin
                            oe_q  <= 1'b1;
                            cmd_q <= tx_q[SHORT_FRAME_W-1];
                            cnt_q <= cnt_q + 8'd1;
                        end
                    end
                end
                S_RX_WAIT: begin
                    if (sd_tick_i && !sd_cmd_i) begin
                        state_q <= S_RX;
                        cnt_q   <= 8'd1;
                    end
                end
                S_RX: begin
                    if (sd_tick_i) begin
                        cnt_q <= cnt_q + 8'd1;
                        if (cnt_q == rx_len - 8'd1) begin
                            state_q <= S_DONE;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk_i) begin
        if (state_q == S_IDLE && start_i) begin
            tx_q    <= {tx_head, crc7(tx_head), 1'b1};
            rx_q    <= '0;
            index_q <= cmd_i.index;
            resp_q  <= cmd_i.resp;
        end
        if (state_q == S_TX && sd_tick_i) begin
            tx_q <= {tx_q[SHORT_FRAME_W-2:0], 1'b0};
        end
        if (sd_tick_i && (state_q == S_RX || (state_q == S_RX_WAIT && !sd_cmd_i))) begin
            rx_q <= {rx_q[LONG_FRAME_W-2:0], sd_cmd_i};
        end
    end

    // crc and index only mean something for 48-bit frames
    assign crc_ok   = (crc7(rx_q[47:8]) == rx_q[7:1]);
    assign index_ok = (rx_q[45:40] == index_q);

    assign result_o    = {crc_ok, index_ok, rx_q[RESP_W+7:8]};
    assign done_o      = (state_q == S_DONE);
    assign sd_cmd_o    = cmd_q;
    assign sd_cmd_oe_o = oe_q;

    no_drive_in_rx: assert property (@(posedge aclk_i) disable iff (reset_i)
        (state_q == S_RX_WAIT || state_q == S_RX) |-> !sd_cmd_oe_o);

endmodule

`default_nettype wire

/* sd_emmc_controller.f */
sd_pkg.sv
sd_apb_regs.sv
sd_clock_divider.sv
sd_cmd_master.sv
sd_cmd_serial_host.sv
sd_emmc_controller.sv
sd_card_model.sv
tb_sd_emmc_controller.sv

/* sd_emmc_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module sd_emmc_controller #(
    parameter int DIV_W = 8
) (
    input  logic                          aclk_i,
    input  logic                          reset_i,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [sd_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [31:0]                   pwdata_i,
    output logic [31:0]                   prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    output logic                          sd_clk_o,
    output logic                          sd_cmd_o,
    output logic                          sd_cmd_oe_o,
    input  logic                          sd_cmd_i,
    output logic                          interrupt_o
);
    import sd_pkg::*;

    sd_cmd_t                  reg_cmd;
    sd_cmd_t                  host_cmd;
    sd_cmd_result_t           host_result;
    sd_cmd_int_t              cmd_events;
    logic [CMD_TIMEOUT_W-1:0] timeout;
    logic [DIV_W-1:0]         divisor;
    logic [31:0]              resp0;
    logic [31:0]              resp1;
    logic [31:0]              resp2;
    logic [31:0]              resp3;
    logic                     cmd_start;
    logic                     cmd_busy;
    logic                     clk_stable;
    logic                     div_load;
    logic                     soft_rst;
    logic                     sd_tick;
    logic                     host_start;
    logic                     host_abort;
    logic                     host_done;

    sd_apb_regs #(
        .DIV_W(DIV_W)
    ) u_regs (
        .aclk_i       (aclk_i),
        .reset_i      (reset_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .clk_stable_i (clk_stable),
        .cmd_busy_i   (cmd_busy),
        .resp_i       ({resp3, resp2, resp1, resp0}),
        .cmd_events_i (cmd_events),
        .cmd_o        (reg_cmd),
        .cmd_start_o  (cmd_start),
        .timeout_o    (timeout),
        .divisor_o    (divisor),
        .div_load_o   (div_load),
        .soft_rst_o   (soft_rst),
        .interrupt_o  (interrupt_o)
    );

    sd_clock_divider #(
        .DIV_W(DIV_W)
    ) u_clk_div (
        .aclk_i       (aclk_i),
        .reset_i      (reset_i),
        .divisor_i    (divisor),
        .div_load_i   (div_load),
        .sd_clk_o     (sd_clk_o),
        .sd_tick_o    (sd_tick),
        .clk_stable_o (clk_stable)
    );

    sd_cmd_master u_cmd_master (
        .aclk_i       (aclk_i),
        .reset_i      (reset_i),
        .soft_rst_i   (soft_rst),
        .sd_tick_i    (sd_tick),
        .cmd_i        (reg_cmd),
        .cmd_start_i  (cmd_start),
        .timeout_i    (timeout),
        .host_done_i  (host_done),
        .result_i     (host_result),
        .host_start_o (host_start),
        .host_cmd_o   (host_cmd),
        .host_abort_o (host_abort),
        .cmd_busy_o   (cmd_busy),
        .events_o     (cmd_events),
        .resp0_o      (resp0),
        .resp1_o      (resp1),
        .resp2_o      (resp2),
        .resp3_o      (resp3)
    );

    sd_cmd_serial_host u_cmd_host (
        .aclk_i      (aclk_i),
        .reset_i     (reset_i),
        .soft_rst_i  (soft_rst),
        .abort_i     (host_abort),
        .sd_tick_i   (sd_tick),
        .start_i     (host_start),
        .cmd_i       (host_cmd),
        .sd_cmd_i    (sd_cmd_i),
        .sd_cmd_o    (sd_cmd_o),
        .sd_cmd_oe_o (sd_cmd_oe_o),
        .done_o      (host_done),
        .result_o    (host_result)
    );

endmodule

`default_nettype wire

/* sd_pkg.sv */
`default_nettype none

package sd_pkg;

    localparam int APB_ADDR_W    = 8;
    localparam int CMD_TIMEOUT_W = 16;
    localparam int RESP_W        = 120;
    localparam int SHORT_FRAME_W = 48;
    localparam int LONG_FRAME_W  = 136;

    // register map, byte offsets
    localparam logic [APB_ADDR_W-1:0] REG_ARGUMENT   = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_COMMAND    = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_TIMEOUT    = 8'h08;
    localparam logic [APB_ADDR_W-1:0] REG_CLK_DIV    = 8'h0C;
    localparam logic [APB_ADDR_W-1:0] REG_RESP0      = 8'h10;
    localparam logic [APB_ADDR_W-1:0] REG_RESP1      = 8'h14;
    localparam logic [APB_ADDR_W-1:0] REG_RESP2      = 8'h18;
    localparam logic [APB_ADDR_W-1:0] REG_RESP3      = 8'h1C;
    localparam logic [APB_ADDR_W-1:0] REG_INT_STATUS = 8'h20;
    localparam logic [APB_ADDR_W-1:0] REG_INT_ENABLE = 8'h24;
    localparam logic [APB_ADDR_W-1:0] REG_PRESENT    = 8'h28;
    localparam logic [APB_ADDR_W-1:0] REG_SOFT_RESET = 8'h2C;

    typedef enum logic [1:0] {
        RESP_NONE       = 2'd0,
        RESP_SHORT      = 2'd1,
        RESP_LONG       = 2'd2,
        RESP_SHORT_BUSY = 2'd3
    } sd_resp_e;

    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] argument;
        sd_resp_e    resp;
    } sd_cmd_t;

    typedef struct packed {
        logic              crc_ok;
        logic              index_ok;
        logic [RESP_W-1:0] payload;
    } sd_cmd_result_t;

    // complete lands in bit 0 of the status word
    typedef struct packed {
        logic index_err;
        logic crc_err;
        logic timeout_err;
        logic complete;
    } sd_cmd_int_t;

    // x^7 + x^3 + 1, msb first
    function automatic logic [6:0] crc7(input logic [39:0] data);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = data[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

endpackage

`default_nettype wire

/* tb_sd_emmc_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_sd_emmc_controller;
    import sd_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int DIVISOR       = 3;
    localparam int SD_PERIOD     = 2 * (DIVISOR + 1) * CLK_PERIOD;
    localparam int TIMEOUT_TICKS = 160;
    localparam int N_CMDS        = 8;
    localparam int WATCHDOG_NS   = N_CMDS * 200 * SD_PERIOD;

    logic                  aclk = 1'b0;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  sd_clk;
    logic                  sd_cmd;
    logic                  sd_cmd_oe;
    logic                  card_cmd;
    logic                  irq;
    logic                  frame_err;
    int                    frame_cnt;
    logic [31:0]           rdata;
    logic                  slverr;
    logic [31:0]           arg;
    int                    frames_before;
    time                   t_rise;

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    sd_emmc_controller #(
        .DIV_W(8)
    ) uut (
        .aclk_i      (aclk),
        .reset_i     (reset),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .paddr_i     (paddr),
        .pwdata_i    (pwdata),
        .prdata_o    (prdata),
        .pready_o    (pready),
        .pslverr_o   (pslverr),
        .sd_clk_o    (sd_clk),
        .sd_cmd_o    (sd_cmd),
        .sd_cmd_oe_o (sd_cmd_oe),
        .sd_cmd_i    (card_cmd),
        .interrupt_o (irq)
    );

    sd_card_model card (
        .aclk_i      (aclk),
        .sd_clk_i    (sd_clk),
        .sd_cmd_i    (sd_cmd),
        .sd_cmd_oe_i (sd_cmd_oe),
        .sd_cmd_o    (card_cmd),
        .frame_err_o (frame_err),
        .frame_cnt_o (frame_cnt)
    );

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    // setup and access phase, response sampled at the completing edge
    task automatic apb_access(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                              input logic [31:0] data);
        @(negedge aclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge aclk);
        penable = 1'b1;
        @(posedge aclk);
        rdata  = prdata;
        slverr = pslverr;
        @(negedge aclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic expect_reg(input string name, input logic [APB_ADDR_W-1:0] addr,
                              input logic [31:0] exp);
        apb_access(1'b0, addr, '0);
        expect_eq(name, exp, rdata);
        expect_eq({name, " pslverr"}, 32'h0, 32'(slverr));
    endtask

    task automatic launch(input logic [5:0] index, input logic [1:0] resp, input logic [31:0] a);
        apb_access(1'b1, REG_ARGUMENT, a);
        apb_access(1'b1, REG_COMMAND, {22'd0, resp, 2'd0, index});
    endtask

    task automatic wait_complete();
        rdata = '0;
        while (!rdata[0]) begin
            apb_access(1'b0, REG_INT_STATUS, '0);
        end
    endtask

    task automatic run_cmd(input string name, input logic [5:0] index, input logic [1:0] resp,
                           input logic [31:0] a, input logic [31:0] exp_status);
        launch(index, resp, a);
        wait_complete();
        expect_eq({name, " status"}, exp_status, rdata);
        // clock stable, inhibit released
        expect_reg({name, " present"}, REG_PRESENT, 32'h2);
    endtask

    task automatic clear_status(input string name, input logic [3:0] bits, input logic [3:0] left);
        apb_access(1'b1, REG_INT_STATUS, {28'd0, bits});
        expect_reg(name, REG_INT_STATUS, {28'd0, left});
    endtask

    card_frames_ok: assert property (@(posedge aclk) !frame_err)
        else abort_run("card model saw a bad frame or a command line that was not driven right");

    access_ready: assert property (@(posedge aclk) disable iff (reset) (psel && penable) |-> pready)
        else abort_run("pready was low during an APB access phase");

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run("timeout: the tests did not finish in the allowed time");
    end

    initial begin
        void'($urandom(32'h3fa8_af3d));
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (4) @(negedge aclk);
        reset = 1'b0;

        expect_reg("reset present", REG_PRESENT, 32'h0);
        expect_eq("reset interrupt", 32'h0, 32'(irq));

        apb_access(1'b1, REG_CLK_DIV, DIVISOR);
        rdata = '0;
        while (!rdata[1]) begin
            apb_access(1'b0, REG_PRESENT, '0);
        end
        @(posedge sd_clk);
        t_rise = $time;
        @(posedge sd_clk);
        expect_eq("sd clock period", 32'(2 * (DIVISOR + 1)), 32'(($time - t_rise) / CLK_PERIOD));
        apb_access(1'b1, REG_TIMEOUT, TIMEOUT_TICKS);

        arg = $urandom();
        run_cmd("short", 6'd8, RESP_SHORT, arg, 32'h1);
        expect_reg("short resp0", REG_RESP0, ~arg);
        clear_status("short clear", 4'h1, 4'h0);

        arg = $urandom();
        run_cmd("long", 6'd2, RESP_LONG, arg, 32'h1);
        expect_reg("long resp0", REG_RESP0, arg);
        expect_reg("long resp1", REG_RESP1, ~arg);
        expect_reg("long resp2", REG_RESP2, arg);
        expect_reg("long resp3", REG_RESP3, {8'd0, arg[23:0]});
        clear_status("long clear", 4'h1, 4'h0);

        // timeout, with its interrupt enabled
        apb_access(1'b1, REG_INT_ENABLE, 32'h2);
        run_cmd("timeout", 6'd5, RESP_SHORT, $urandom(), 32'h3);
        expect_eq("timeout interrupt", 32'h1, 32'(irq));
        clear_status("timeout clear complete", 4'h1, 4'h2);
        expect_eq("timeout interrupt kept", 32'h1, 32'(irq));
        clear_status("timeout clear error", 4'h2, 4'h0);
        expect_eq("timeout interrupt cleared", 32'h0, 32'(irq));

        // crc error, masked first
        apb_access(1'b1, REG_INT_ENABLE, 32'h0);
        run_cmd("crc", 6'd13, RESP_SHORT, $urandom(), 32'h5);
        expect_eq("crc interrupt masked", 32'h0, 32'(irq));
        apb_access(1'b1, REG_INT_ENABLE, 32'h4);
        @(negedge aclk);
        expect_eq("crc interrupt", 32'h1, 32'(irq));
        clear_status("crc clear error", 4'h4, 4'h1);
        expect_eq("crc interrupt cleared", 32'h0, 32'(irq));
        clear_status("crc clear complete", 4'h1, 4'h0);

        run_cmd("index", 6'd17, RESP_SHORT, $urandom(), 32'h9);
        clear_status("index clear error", 4'h8, 4'h1);
        clear_status("index clear complete", 4'h1, 4'h0);

        // second write while inhibited must not launch
        frames_before = frame_cnt;
        arg = $urandom();
        launch(6'd8, RESP_SHORT, arg);
        expect_reg("inhibit set", REG_PRESENT, 32'h3);
        apb_access(1'b1, REG_COMMAND, {22'd0, 2'd1, 2'd0, 6'd9});
        wait_complete();
        expect_eq("inhibit status", 32'h1, rdata);
        expect_eq("inhibit frames", 32'(frames_before + 1), 32'(frame_cnt));
        expect_reg("inhibit command", REG_COMMAND, 32'h108);
        expect_reg("inhibit resp0", REG_RESP0, ~arg);
        clear_status("inhibit clear", 4'h1, 4'h0);

        // soft reset while waiting for a response that never comes
        frames_before = frame_cnt;
        launch(6'd5, RESP_SHORT, $urandom());
        wait (frame_cnt == frames_before + 1);
        apb_access(1'b1, REG_SOFT_RESET, 32'h1);
        expect_reg("soft reset present", REG_PRESENT, 32'h2);
        repeat (TIMEOUT_TICKS + 4) @(posedge sd_clk);
        expect_reg("soft reset events", REG_INT_STATUS, 32'h0);

        arg = $urandom();
        run_cmd("after soft reset", 6'd8, RESP_SHORT, arg, 32'h1);
        expect_reg("after soft reset resp0", REG_RESP0, ~arg);
        clear_status("after soft reset clear", 4'h1, 4'h0);

        apb_access(1'b1, 8'h30, 32'hffff_ffff);
        expect_eq("unmapped write pslverr", 32'h1, 32'(slverr));
        apb_access(1'b0, 8'h30, '0);
        expect_eq("unmapped read pslverr", 32'h1, 32'(slverr));
        apb_access(1'b1, REG_RESP0, arg);
        expect_eq("resp0 write pslverr", 32'h1, 32'(slverr));
        apb_access(1'b1, REG_PRESENT, 32'h0);
        expect_eq("present write pslverr", 32'h1, 32'(slverr));
        expect_reg("resp0 kept", REG_RESP0, ~arg);
        expect_reg("argument kept", REG_ARGUMENT, arg);
        expect_reg("present kept", REG_PRESENT, 32'h2);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
